//--- dv/fifo_async_stimulus.txt
// Stimulus for tb_fifo_async_bridge. Every value is hex.
// First value: expected capacity in words. Then one header line per test:
//   test number, word count, write-gap %, read-ack %, data-from-file flag
// With the flag set, that many data words follow. Test number 0 ends the list.
10
// Full rate on both sides, explicit words.
1 8 0 64 1
a5a5 5a5a 0001 8000
ffff 0000 1234 fedc
// read_ack held low until the capacity is measured.
2 14 0 0 0
// Random gaps and acks, words from the xorshift stream.
3 40 19 32 0
4 c8 32 19 0
// Explicit words against a bursty reader.
5 c 0 4b 1
0f0f f0f0 3c3c c3c3
0102 0408 1020 4080
7fff 8001 55aa aa55
0

//--- src.f
design/fifo_pkg.sv
design/fifo_mem_if.sv
design/gray_counter.sv
design/cdc_sync.sv
design/fifo_mem.sv
design/write_ctrl.sv
design/read_fsm.sv
design/read_ctrl.sv
design/fifo_async_bridge.sv
dv/tb_fifo_async_bridge.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the FIFO bridge testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_fifo_async_bridge -f src.f -o sim_fifo
./obj_dir/sim_fifo | tee sim.log

# The run passes only when the testbench reports success.
grep -q "All tests passed" sim.log

//--- dv/tb_fifo_async_bridge.sv
`timescale 1ns/1ps

module tb_fifo_async_bridge;

    localparam int WIDTH = 16;

    logic             WRITE_CLK;
    logic             READ_CLK;
    logic             READ_RESET_IN;
    logic [WIDTH-1:0] write_data;
    logic             write_req;
    logic             write_ack;
    logic [WIDTH-1:0] read_data;
    logic             read_req;
    logic             read_ack;

    logic [31:0]      stim [512];
    logic [WIDTH-1:0] expected [$];  // Scoreboard in write order.
    logic [31:0]      wr_rng;
    logic [31:0]      rd_rng;
    int               ack_pct;
    int               capacity;
    int               errors;
    int               passed;
    int               failed;
    int               test_writes;
    int               test_reads;
    int               wd_limit_ns;

    fifo_async_bridge #(.WIDTH(WIDTH)) u_fifo_async_bridge (.*);

    initial begin
        WRITE_CLK = 1'b0;
        forever #2 WRITE_CLK = ~WRITE_CLK;
    end

    initial begin
        READ_CLK = 1'b0;
        forever #3 READ_CLK = ~READ_CLK;
    end

    // ##############################
    // Helpers
    // ##############################

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int total_words();
        int p;
        int sum;
        p = 1;
        sum = 0;
        while (stim[p] != 0) begin
            sum += stim[p+1];
            p += 5 + (stim[p+4][0] ? stim[p+1] : 0);
        end
        return sum;
    endfunction

    // write_ack only moves on a rising edge, so the falling edge sees the accept decision.
    task automatic drive_writes(input int n, input int gap, input int base, input bit from_file);
        int               sent;
        bit               have;
        logic [WIDTH-1:0] word;
        sent = 0;
        have = 1'b0;
        while (sent < n) begin
            @(negedge WRITE_CLK);
            if (!have) begin
                wr_rng = xorshift(wr_rng);
                if ((wr_rng % 100) >= gap) begin
                    have = 1'b1;
                    wr_rng = xorshift(wr_rng);
                    word = from_file ? stim[base+sent][WIDTH-1:0] : wr_rng[WIDTH-1:0];
                end
            end
            write_req  = have;
            write_data = have ? word : '0;
            if (have && write_ack) begin  // Taken on the next rising edge.
                expected.push_back(word);
                sent++;
                test_writes++;
                have = 1'b0;
            end
        end
        @(negedge WRITE_CLK);
        write_req = 1'b0;
    endtask

    task automatic drain_reads(input int n);
        bit               held;
        logic [WIDTH-1:0] last;
        logic [WIDTH-1:0] exp_word;
        held = 1'b0;
        while (test_reads < n) begin
            @(negedge READ_CLK);
            if (held) begin
                assert (read_req === 1'b1) else begin
                    $display("ERR read_req expected 1 actual %h", read_req);
                    errors++;
                end
                assert (read_data === last) else begin
                    $display("ERR read_data expected %h actual %h", last, read_data);
                    errors++;
                end
            end
            rd_rng = xorshift(rd_rng);
            read_ack = ((rd_rng % 100) < ack_pct);
            if (read_req && read_ack) begin
                assert (expected.size() != 0) else begin
                    $display("read_req offered a word that was never written");
                    errors++;
                end
                if (expected.size() != 0) begin
                    exp_word = expected.pop_front();
                    assert (read_data === exp_word) else begin
                        $display("ERR read_data expected %h actual %h", exp_word, read_data);
                        errors++;
                    end
                end
                test_reads++;
            end
            held = read_req && !read_ack;
            last = read_data;
        end
        @(negedge READ_CLK);
        read_ack = 1'b0;
    endtask

    // Reader stalled, so write_ack must settle low after exactly capacity accepts.
    task automatic measure_capacity();
        int low_run;
        low_run = 0;
        while (low_run < 32) begin
            @(negedge WRITE_CLK);
            low_run = write_ack ? 0 : low_run + 1;
        end
        assert (test_writes == capacity) else begin
            $display("ERR write_accepts expected %h actual %h", capacity, test_writes);
            errors++;
        end
        ack_pct = 100;
    endtask

    // Reader keeps accepting, so any word offered after the drain is counted.
    task automatic check_idle();
        repeat (10) begin
            @(negedge READ_CLK);
            assert (read_req === 1'b0) else begin
                $display("ERR read_req expected 0 actual %h", read_req);
                errors++;
            end
            if (read_req === 1'b1) begin
                test_reads++;
            end
            read_ack = 1'b1;
        end
        @(negedge READ_CLK);
        read_ack = 1'b0;
        @(negedge WRITE_CLK);
        assert (write_ack === 1'b1) else begin
            $display("ERR write_ack expected 1 actual %h", write_ack);
            errors++;
        end
        assert (test_reads == test_writes) else begin
            $display("ERR read_count expected %h actual %h", test_writes, test_reads);
            errors++;
        end
    endtask

    task automatic log_result(input int num, input int words, input int errs_before);
        if (errors == errs_before) begin
            passed++;
            $display("test %0d: PASS, %0d words", num, words);
        end else begin
            failed++;
            $display("test %0d: FAIL, %0d words, %0d errors", num, words, errors - errs_before);
        end
    endtask

    // ##############################
    // Main sequence
    // ##############################

    initial begin
        int p;
        int num;
        int words;
        int gap;
        int errs_before;
        bit from_file;
        READ_RESET_IN = 1'b1;
        write_req     = 1'b0;
        write_data    = '0;
        read_ack      = 1'b0;
        errors        = 0;
        passed        = 0;
        failed        = 0;
        wr_rng        = 32'h9c5b;
        rd_rng        = xorshift(32'h9c5b);
        foreach (stim[i]) stim[i] = '0;
        $readmemh("dv/fifo_async_stimulus.txt", stim);
        capacity    = stim[0];
        wd_limit_ns = 2000 + 20 * 6 * total_words();  // 20 read periods per word.
        repeat (16) @(posedge WRITE_CLK);
        @(negedge WRITE_CLK);
        READ_RESET_IN = 1'b0;
        repeat (6) @(negedge READ_CLK);
        errs_before = errors;
        assert (read_req === 1'b0 && write_ack === 1'b1) else begin
            $display("ERR read_req/write_ack expected 0/1 actual %h/%h", read_req, write_ack);
            errors++;
        end
        log_result(0, 0, errs_before);
        p = 1;
        while (stim[p] != 0) begin
            num         = stim[p];
            words       = stim[p+1];
            gap         = stim[p+2];
            ack_pct     = stim[p+3];
            from_file   = stim[p+4][0];
            test_writes = 0;
            test_reads  = 0;
            errs_before = errors;
            fork
                drive_writes(words, gap, p + 5, from_file);
                drain_reads(words);
                if (ack_pct == 0) measure_capacity();
            join
            check_idle();
            log_result(num, words, errs_before);
            p += 5 + (from_file ? words : 0);
        end
        $display("Summary: %0d tests passing, %0d failing", passed, failed);
        if (failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        wait (wd_limit_ns > 0);
        #(wd_limit_ns);
        $display("Watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- design/fifo_async_bridge.sv
`timescale 1ns/1ps

module fifo_async_bridge
    import fifo_pkg::*;
#(
    parameter int WIDTH = 16
) (
    input  logic             WRITE_CLK,
    input  logic             READ_CLK,
    input  logic             READ_RESET_IN,  // Resets both domains.
    input  logic [WIDTH-1:0] write_data,
    input  logic             write_req,
    output logic             write_ack,
    output logic [WIDTH-1:0] read_data,
    output logic             read_req,
    input  logic             read_ack
);

    gray_t wr_gray;
    gray_t rd_gray;

    fifo_mem_if #(.WIDTH(WIDTH)) u_mem_if ();

    write_ctrl #(.WIDTH(WIDTH)) u_write_ctrl (
        .clk     (WRITE_CLK),
        .rst     (READ_RESET_IN),
        .data    (write_data),
        .req     (write_req),
        .ack     (write_ack),
        .rd_gray (rd_gray),
        .wr_gray (wr_gray),
        .mem     (u_mem_if.writer)
    );

    read_ctrl #(.WIDTH(WIDTH)) u_read_ctrl (
        .clk     (READ_CLK),
        .rst     (READ_RESET_IN),
        .wr_gray (wr_gray),
        .rd_gray (rd_gray),
        .data    (read_data),
        .req     (read_req),
        .ack     (read_ack),
        .mem     (u_mem_if.reader)
    );

    fifo_mem #(.WIDTH(WIDTH)) u_fifo_mem (.clk(WRITE_CLK), .mem(u_mem_if.mem));

endmodule

//--- design/read_ctrl.sv
`timescale 1ns/1ps

module read_ctrl
    import fifo_pkg::*;
#(
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  gray_t            wr_gray,
    output gray_t            rd_gray,
    output logic [WIDTH-1:0] data,
    output logic             req,
    input  logic             ack,
    fifo_mem_if.reader       mem
);

    logic [1:0] rst_pipe;
    logic       rd_rst;
    addr_t      rd_bin;
    gray_t      wr_gray_sync;
    logic       avail;
    logic       pop;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rst_pipe <= 2'b11;
        end else begin
            rst_pipe <= {rst_pipe[0], 1'b0};
        end
    end
    assign rd_rst = rst_pipe[1];  // Read-domain release.

    gray_counter u_rd_ptr (
        .clk       (clk),
        .rst       (rd_rst),
        .inc       (pop),
        .bin       (rd_bin),
        .gray      (rd_gray),
        .gray_next ()
    );

    cdc_sync u_wr_sync (.clk(clk), .rst(rd_rst), .src(wr_gray), .dst(wr_gray_sync));

    assign avail       = (wr_gray_sync != rd_gray);  // Not empty.
    assign mem.rd_addr = rd_bin;

    read_fsm #(.WIDTH(WIDTH)) u_read_fsm (
        .clk   (clk),
        .rst   (rd_rst),
        .avail (avail),
        .head  (mem.rd_data),
        .pop   (pop),
        .data  (data),
        .req   (req),
        .ack   (ack)
    );

    // An idle output stage picks up waiting data on the very next edge.
    a_fill: assert property (
        @(posedge clk) disable iff (rd_rst)
        (u_read_fsm.state == OUT_EMPTY) && avail |=> req
    );

endmodule

//--- design/read_fsm.sv
`timescale 1ns/1ps

module read_fsm
    import fifo_pkg::*;
#(
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             avail,
    input  logic [WIDTH-1:0] head,
    output logic             pop,
    output logic [WIDTH-1:0] data,
    output logic             req,
    input  logic             ack
);

    out_state_t state;
    out_state_t state_next;

    // ##############################
    // Next state and pop
    // ##############################

    always_comb begin
        state_next = state;
        pop        = 1'b0;
        case (state)
            OUT_EMPTY: begin
                if (avail) begin
                    pop        = 1'b1;
                    state_next = OUT_VALID;
                end
            end
            OUT_VALID: begin
                if (ack) begin
                    pop        = avail;  // Reload behind the word just taken.
                    state_next = avail ? OUT_VALID : OUT_EMPTY;
                end
            end
            default: state_next = OUT_EMPTY;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= OUT_EMPTY;
        end else begin
            state <= state_next;
        end
    end

    // Output word register.
    always_ff @(posedge clk) begin
        if (pop) begin
            data <= head;
        end
    end

    assign req = (state == OUT_VALID);  // Straight from the state flop.

    // Offered word holds until taken.
    a_hold: assert property (
        @(posedge clk) disable iff (rst)
        req && !ack |=> req && $stable(data)
    );

endmodule

//--- design/write_ctrl.sv
`timescale 1ns/1ps

module write_ctrl
    import fifo_pkg::*;
#(
    parameter int WIDTH = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [WIDTH-1:0]  data,
    input  logic              req,
    output logic              ack,
    input  gray_t             rd_gray,
    output gray_t             wr_gray,
    fifo_mem_if.writer        mem
);

    logic [1:0] rst_pipe;
    logic       wr_rst;
    addr_t      wr_bin;
    gray_t      wr_gray_next;
    gray_t      rd_gray_sync;

    // Assert asynchronously, release on the second write clock edge.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rst_pipe <= 2'b11;
        end else begin
            rst_pipe <= {rst_pipe[0], 1'b0};
        end
    end
    assign wr_rst = rst_pipe[1];

    gray_counter u_wr_ptr (
        .clk       (clk),
        .rst       (wr_rst),
        .inc       (mem.wr_en),
        .bin       (wr_bin),
        .gray      (wr_gray),
        .gray_next (wr_gray_next)
    );

    cdc_sync u_rd_sync (.clk(clk), .rst(wr_rst), .src(rd_gray), .dst(rd_gray_sync));

    assign ack = (wr_gray_next != rd_gray_sync);  // One slot kept free.

    assign mem.wr_en   = req & ack;
    assign mem.wr_addr = wr_bin;
    assign mem.wr_data = data;

    // No write into a full FIFO, and a fresh word never looks already read.
    a_no_overrun: assert property (
        @(posedge clk) disable iff (wr_rst)
        mem.wr_en |-> ack ##1 (wr_gray != rd_gray_sync)
    );

endmodule

//--- design/fifo_mem.sv
`timescale 1ns/1ps

module fifo_mem
    import fifo_pkg::*;
#(
    parameter int WIDTH = 16
) (
    input logic     clk,  // Write clock.
    fifo_mem_if.mem mem
);

    // ##############################
    // Storage
    // ##############################

    logic [WIDTH-1:0] ram [DEPTH];

    always_ff @(posedge clk) begin
        if (mem.wr_en) begin
            ram[mem.wr_addr] <= mem.wr_data;
        end
    end

    // Asynchronous read. The slot is stable long before the reader sees it.
    assign mem.rd_data = ram[mem.rd_addr];

endmodule

//--- design/cdc_sync.sv
`timescale 1ns/1ps

module cdc_sync
    import fifo_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  gray_t src,
    output gray_t dst
);

    gray_t meta;

    function automatic addr_t to_bin(gray_t g);
        addr_t b;
        b[ADDR_W-1] = g[ADDR_W-1];
        for (int i = ADDR_W - 2; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            meta <= '0;
            dst  <= '0;
        end else begin
            meta <= src;   // May go metastable.
            dst  <= meta;
        end
    end

    // The far pointer only ever moves forward, by less than half the ring.
    a_fwd_only: assert property (
        @(posedge clk) disable iff (rst)
        addr_t'(to_bin(dst) - to_bin($past(dst))) < addr_t'(DEPTH / 2)
    );

endmodule

//--- design/gray_counter.sv
`timescale 1ns/1ps

module gray_counter
    import fifo_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  inc,
    output addr_t bin,
    output gray_t gray,
    output gray_t gray_next
);

    addr_t bin_inc;

    assign bin_inc   = addr_t'(bin + 1'b1);
    assign gray_next = bin_inc ^ (bin_inc >> 1);

    // Binary count drives the address, the Gray copy crosses domains.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bin  <= '0;
            gray <= '0;
        end else if (inc) begin
            bin  <= bin_inc;
            gray <= gray_next;  // Registered, so no glitches reach the far side.
        end
    end

    // One bit flips per step, wrap included.
    a_gray_step: assert property (
        @(posedge clk) disable iff (rst)
        inc |=> $countones(gray ^ $past(gray)) == 1
    );

endmodule

//--- design/fifo_mem_if.sv
`timescale 1ns/1ps

interface fifo_mem_if
    import fifo_pkg::*;
#(
    parameter int WIDTH = 16
) ();

    logic             wr_en;
    addr_t            wr_addr;
    logic [WIDTH-1:0] wr_data;
    addr_t            rd_addr;
    logic [WIDTH-1:0] rd_data;

    // Write domain side.
    modport writer (output wr_en, output wr_addr, output wr_data);

    // Read domain side.
    modport reader (output rd_addr, input rd_data);

    modport mem (input wr_en, input wr_addr, input wr_data, input rd_addr, output rd_data);

endinterface

//--- design/fifo_pkg.sv
package fifo_pkg;

    // ##############################
    // Depth and pointer widths
    // ##############################

    localparam int ADDR_W = 4;            // Address bits.
    localparam int DEPTH  = 1 << ADDR_W;  // 16 entries.

    // ##############################
    // Types
    // ##############################

    // Binary memory address.
    typedef logic [ADDR_W-1:0] addr_t;

    // Gray-coded pointer, the only form that crosses clock domains.
    typedef logic [ADDR_W-1:0] gray_t;

    // Read output stage.
    typedef enum logic {
        OUT_EMPTY,
        OUT_VALID
    } out_state_t;

endpackage
